/* mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// memory geometry
`define MEM_DEPTH_LOG2 8   // 256 words of 64 bits

// cycles from valid being sampled to the done pulse
// must be at least 1
`define MEM_LATENCY 3

// byte offset bits inside a 64-bit word
`define MEM_WORD_LSB 3

`endif

/* mem_pkg.sv */
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;   // one bit per byte lane

    typedef logic [`MEM_DEPTH_LOG2-1:0] word_idx_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_serve,     // valid high toward memory
        arb_finish,    // ack raised
        arb_release    // waiting for req to drop
    } arb_state_t;

    typedef enum logic {
        mem_idle,
        mem_busy
    } mem_state_t;

endpackage

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           clk,
    input  logic           rst,

    // fetch side, read only
    input  logic           if_req_i,
    input  mem_pkg::addr_t if_addr_i,
    output logic           if_ack_o,
    output mem_pkg::data_t if_rdata_o,

    // memory-stage side
    input  logic           mem_req_i,
    input  logic           mem_we_i,
    input  mem_pkg::addr_t mem_addr_i,
    input  mem_pkg::data_t mem_wdata_i,
    input  mem_pkg::strb_t mem_strb_i,
    output logic           mem_ack_o,
    output mem_pkg::data_t mem_rdata_o,

    // toward the data memory
    output logic           rd_valid_o,
    output logic           wr_valid_o,
    output mem_pkg::addr_t addr_o,
    output mem_pkg::data_t wdata_o,
    output mem_pkg::strb_t strb_o,
    input  logic           done_i,
    input  mem_pkg::data_t rdata_i
);

    mem_pkg::arb_state_t state_q;
    logic                win_mem_q;   // memory stage owns the transfer
    logic                we_q;
    mem_pkg::addr_t      addr_q;
    mem_pkg::data_t      wdata_q;
    mem_pkg::strb_t      strb_q;
    mem_pkg::data_t      if_rdata_q;
    mem_pkg::data_t      mem_rdata_q;

    logic                holding;     // ack phase of the handshake
    logic                win_req;

    assign holding = (state_q == mem_pkg::arb_finish) || (state_q == mem_pkg::arb_release);
    assign win_req = win_mem_q ? mem_req_i : if_req_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= mem_pkg::arb_idle;
            win_mem_q <= 1'b0;
        end else begin
            unique case (state_q)
                mem_pkg::arb_idle: begin
                    if (mem_req_i) begin          // memory stage first
                        win_mem_q <= 1'b1;
                        state_q   <= mem_pkg::arb_serve;
                    end else if (if_req_i) begin
                        win_mem_q <= 1'b0;
                        state_q   <= mem_pkg::arb_serve;
                    end
                end
                mem_pkg::arb_serve: begin
                    if (done_i) begin
                        state_q <= mem_pkg::arb_finish;
                    end
                end
                mem_pkg::arb_finish: begin
                    if (!win_req) begin
                        state_q <= mem_pkg::arb_idle;
                    end else begin
                        state_q <= mem_pkg::arb_release;
                    end
                end
                mem_pkg::arb_release: begin
                    if (!win_req) begin           // requester let go
                        state_q <= mem_pkg::arb_idle;
                    end
                end
                default: begin
                    state_q <= mem_pkg::arb_idle;
                end
            endcase
        end
    end

    // request fields, captured at grant
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::arb_idle) begin
            if (mem_req_i) begin
                we_q    <= mem_we_i;
                addr_q  <= mem_addr_i;
                wdata_q <= mem_wdata_i;
                strb_q  <= mem_strb_i;
            end else if (if_req_i) begin
                we_q    <= 1'b0;
                addr_q  <= if_addr_i;
                wdata_q <= '0;
                strb_q  <= '0;
            end
        end
    end

    // read data, one register per requester
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::arb_serve && done_i && !we_q) begin
            if (win_mem_q) begin
                mem_rdata_q <= rdata_i;
            end else begin
                if_rdata_q <= rdata_i;
            end
        end
    end

    assign rd_valid_o = (state_q == mem_pkg::arb_serve) && !we_q;
    assign wr_valid_o = (state_q == mem_pkg::arb_serve) && we_q;
    assign addr_o     = addr_q;
    assign wdata_o    = wdata_q;
    assign strb_o     = strb_q;

    assign if_ack_o    = holding && !win_mem_q;
    assign mem_ack_o   = holding && win_mem_q;
    assign if_rdata_o  = if_rdata_q;
    assign mem_rdata_o = mem_rdata_q;

endmodule

/* data_memory.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module data_memory (
    input  logic           clk,
    input  logic           rst,
    input  logic           rd_valid_i,
    input  logic           wr_valid_i,
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::data_t wdata_i,
    input  mem_pkg::strb_t strb_i,
    output logic           done_o,
    output mem_pkg::data_t rdata_o
);

    localparam int WORDS = 1 << `MEM_DEPTH_LOG2;
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    mem_pkg::data_t      mem_q [0:WORDS-1];
    mem_pkg::mem_state_t state_q;
    logic [CNT_W-1:0]    cnt_q;
    mem_pkg::word_idx_t  idx;
    logic                start;
    logic                fire;     // last cycle of the access

    assign idx = addr_i[`MEM_WORD_LSB +: `MEM_DEPTH_LOG2];

    // done_o still high means the valid is the one just served
    assign start = (state_q == mem_pkg::mem_idle) && (rd_valid_i || wr_valid_i) && !done_o;
    assign fire  = (state_q == mem_pkg::mem_busy) && (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= mem_pkg::mem_idle;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            unique case (state_q)
                mem_pkg::mem_idle: begin
                    if (start) begin
                        cnt_q   <= CNT_W'(`MEM_LATENCY - 1);
                        state_q <= mem_pkg::mem_busy;
                    end
                end
                mem_pkg::mem_busy: begin
                    if (fire) begin
                        done_o  <= 1'b1;
                        state_q <= mem_pkg::mem_idle;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= mem_pkg::mem_idle;
                end
            endcase
        end
    end

    // storage, byte lanes under strb_i
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (fire && wr_valid_i) begin
            for (int b = 0; b < 8; b++) begin
                if (strb_i[b]) begin
                    mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && rd_valid_i) begin
            rdata_o <= mem_q[idx];
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic           clk,
    input  logic           rst,

    input  logic           if_req_i,
    input  mem_pkg::addr_t if_addr_i,
    output logic           if_ack_o,
    output mem_pkg::data_t if_rdata_o,

    input  logic           mem_req_i,
    input  logic           mem_we_i,
    input  mem_pkg::addr_t mem_addr_i,
    input  mem_pkg::data_t mem_wdata_i,
    input  mem_pkg::strb_t mem_strb_i,
    output logic           mem_ack_o,
    output mem_pkg::data_t mem_rdata_o
);

    // arbiter to memory
    logic           rd_valid;
    logic           wr_valid;
    mem_pkg::addr_t addr;
    mem_pkg::data_t wdata;
    mem_pkg::strb_t strb;
    logic           done;
    mem_pkg::data_t rdata;

    mem_arbiter arb_i (
        .clk         (clk),
        .rst         (rst),
        .if_req_i    (if_req_i),
        .if_addr_i   (if_addr_i),
        .if_ack_o    (if_ack_o),
        .if_rdata_o  (if_rdata_o),
        .mem_req_i   (mem_req_i),
        .mem_we_i    (mem_we_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_strb_i  (mem_strb_i),
        .mem_ack_o   (mem_ack_o),
        .mem_rdata_o (mem_rdata_o),
        .rd_valid_o  (rd_valid),
        .wr_valid_o  (wr_valid),
        .addr_o      (addr),
        .wdata_o     (wdata),
        .strb_o      (strb),
        .done_i      (done),
        .rdata_i     (rdata)
    );

    data_memory mem_i (
        .clk        (clk),
        .rst        (rst),
        .rd_valid_i (rd_valid),
        .wr_valid_i (wr_valid),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .strb_i     (strb),
        .done_o     (done),
        .rdata_o    (rdata)
    );

endmodule

/* tb_mem_subsys_top.sv */
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsys_top;

    localparam int          TIMEOUT  = 50;
    localparam int          N_RANDOM = 150;   // per port
    localparam int          LAT      = `MEM_LATENCY + 2;
    localparam logic [31:0] SEED     = 32'h56b4_e8e4;

    logic           clk;
    logic           rst;
    logic           if_req;
    mem_pkg::addr_t if_addr;
    logic           if_ack;
    mem_pkg::data_t if_rdata;
    logic           mem_req;
    logic           mem_we;
    mem_pkg::addr_t mem_addr;
    mem_pkg::data_t mem_wdata;
    mem_pkg::strb_t mem_strb;
    logic           mem_ack;
    mem_pkg::data_t mem_rdata;

    mem_pkg::data_t model [0:(1 << `MEM_DEPTH_LOG2)-1];
    int             data_errors;
    int             lat_errors;
    int             proto_errors;
    logic [31:0]    mem_rng;
    logic [31:0]    if_rng;
    time            mem_ack_time;
    time            if_ack_time;
    int             if_drop_cnt;
    int             mem_drop_cnt;
    logic           if_ack_prev;
    logic           mem_ack_prev;

    mem_subsys_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .if_req_i    (if_req),
        .if_addr_i   (if_addr),
        .if_ack_o    (if_ack),
        .if_rdata_o  (if_rdata),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_strb_i  (mem_strb),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low bits land in the ignored byte offset
    function automatic mem_pkg::addr_t word_addr(input int w, input int lo);
        return (mem_pkg::addr_t'(w) << `MEM_WORD_LSB) | mem_pkg::addr_t'(lo);
    endfunction

    function automatic int word_of(input mem_pkg::addr_t a);
        return int'(a[`MEM_WORD_LSB +: `MEM_DEPTH_LOG2]);
    endfunction

    task automatic model_write(input mem_pkg::addr_t a, input mem_pkg::data_t d,
                               input mem_pkg::strb_t s);
        for (int b = 0; b < 8; b++) begin
            if (s[b]) model[word_of(a)][b*8 +: 8] = d[b*8 +: 8];
        end
    endtask

    task automatic check_data(input string what, input mem_pkg::data_t got,
                              input mem_pkg::data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("FAILED time %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input string what, input int got, input int exp);
        if (got != exp) begin
            lat_errors++;
            $display("FAILED time %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("time %0t: %s", $time, why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic watch_port(input string name, input logic req, input logic ack,
                              inout int drop, inout logic ack_prev);
        logic was_req;
        was_req = (drop == 0);
        drop = req ? 0 : ((drop < 2) ? drop + 1 : 2);
        if (ack && !ack_prev && !was_req) begin
            proto_errors++;
            $display("time %0t: %s ack rose without a pending req", $time, name);
        end else if (ack && drop >= 2) begin
            proto_errors++;
            $display("time %0t: %s ack still high two edges after req dropped", $time, name);
        end
        ack_prev = ack;
    endtask

    // handshake monitor sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst) begin
            watch_port("fetch", if_req, if_ack, if_drop_cnt, if_ack_prev);
            watch_port("memory-stage", mem_req, mem_ack, mem_drop_cnt, mem_ack_prev);
        end
    end

    // lat counts edges after the one that first sees req
    task automatic mem_transfer(input logic we, input mem_pkg::addr_t a,
                                input mem_pkg::data_t d, input mem_pkg::strb_t s,
                                input int hold, output int lat);
        int cycles;
        mem_we    = we;
        mem_addr  = a;
        mem_wdata = d;
        mem_strb  = s;
        mem_req   = 1'b1;
        @(posedge clk);
        #1;
        cycles = 0;
        while (!mem_ack) begin
            if (cycles >= TIMEOUT) abort_run("timeout waiting for mem_ack_o");
            @(posedge clk);
            #1;
            cycles++;
        end
        lat = cycles;
        mem_ack_time = $time;
        if (we) model_write(a, d, s);
        else check_data("memory-stage read", mem_rdata, model[word_of(a)]);
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        mem_req = 1'b0;
        cycles = 0;
        while (mem_ack) begin
            if (cycles >= TIMEOUT) abort_run("mem_ack_o never fell after mem_req_i dropped");
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic fetch_read(input mem_pkg::addr_t a, input int hold, output int lat);
        int cycles;
        if_addr = a;
        if_req  = 1'b1;
        @(posedge clk);
        #1;
        cycles = 0;
        while (!if_ack) begin
            if (cycles >= TIMEOUT) abort_run("timeout waiting for if_ack_o");
            @(posedge clk);
            #1;
            cycles++;
        end
        lat = cycles;
        if_ack_time = $time;
        check_data("fetch read", if_rdata, model[word_of(a)]);
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        if_req = 1'b0;
        cycles = 0;
        while (if_ack) begin
            if (cycles >= TIMEOUT) abort_run("if_ack_o never fell after if_req_i dropped");
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic mem_random_run();
        logic [31:0]    r;
        mem_pkg::data_t d;
        int             lat;
        for (int n = 0; n < N_RANDOM; n++) begin
            mem_rng = lcg_next(mem_rng);
            r = mem_rng;
            mem_rng = lcg_next(mem_rng);
            d[63:32] = mem_rng;
            mem_rng = lcg_next(mem_rng);
            d[31:0] = mem_rng;
            mem_transfer(r[31], word_addr(int'(r[30:26]), int'(r[25:23])), d, r[18:11],
                         int'(r[22:21]), lat);
            repeat (1 + int'(r[20:19])) begin   // a gap lets fetch win
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic fetch_random_run();
        logic [31:0] r;
        int          lat;
        for (int n = 0; n < N_RANDOM; n++) begin
            if_rng = lcg_next(if_rng);
            r = if_rng;
            fetch_read(word_addr(int'(r[30:26]), int'(r[25:23])), int'(r[22:21]), lat);
            repeat (int'(r[20:19])) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    initial begin
        int lat;
        int lat_if;
        clk = 1'b0;
        rst = 1'b1;
        if_req = 1'b0;
        if_addr = '0;
        mem_req = 1'b0;
        mem_we = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_strb = '0;
        data_errors = 0;
        lat_errors = 0;
        proto_errors = 0;
        mem_rng = SEED;
        if_rng = ~SEED;   // separate stream per port
        mem_ack_time = 0;
        if_ack_time = 0;
        if_drop_cnt = 2;
        mem_drop_cnt = 2;
        if_ack_prev = 1'b0;
        mem_ack_prev = 1'b0;
        for (int i = 0; i < (1 << `MEM_DEPTH_LOG2); i++) model[i] = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (4) begin
            @(posedge clk);
            #1;
            if (if_ack || mem_ack) begin
                proto_errors++;
                $display("time %0t: an ack is high with no request after reset", $time);
            end
        end

        // untouched words read back as zero
        fetch_read(word_addr(0, 0), 0, lat);
        check_latency("fetch read, idle", lat, LAT);
        fetch_read(word_addr(255, 5), 1, lat);
        check_latency("fetch read, idle", lat, LAT);
        mem_transfer(1'b0, word_addr(130, 0), '0, '0, 0, lat);
        check_latency("memory-stage read, idle", lat, LAT);

        // strobed write merges into the old word
        mem_transfer(1'b1, word_addr(5, 0), 64'h1122_3344_5566_7788, 8'hff, 0, lat);
        check_latency("memory-stage write, idle", lat, LAT);
        mem_transfer(1'b1, word_addr(5, 3), 64'hdead_beef_cafe_f00d, 8'h0f, 2, lat);
        mem_transfer(1'b0, word_addr(5, 0), '0, '0, 0, lat);
        check_data("merged word", mem_rdata, 64'h1122_3344_cafe_f00d);
        fetch_read(word_addr(5, 7), 0, lat);
        check_data("merged word by fetch", if_rdata, 64'h1122_3344_cafe_f00d);

        // both raise req on the same edge
        fork
            mem_transfer(1'b1, word_addr(9, 0), 64'h0123_4567_89ab_cdef, 8'hf0, 0, lat);
            fetch_read(word_addr(9, 0), 0, lat_if);
        join
        check_latency("memory-stage write beside fetch", lat, LAT);
        // fetch granted one edge after the arbiter is back in idle
        check_latency("fetch queued behind memory-stage write", lat_if, 2 * LAT + 2);
        if (mem_ack_time >= if_ack_time) begin
            proto_errors++;
            $display("time %0t: fetch was acked before the memory-stage write", $time);
        end
        check_data("fetch after same-edge write", if_rdata, 64'h0123_4567_0000_0000);

        fork
            mem_random_run();
            fetch_random_run();
        join
        repeat (2) @(posedge clk);

        $display("errors: data %0d, latency %0d, protocol %0d",
                 data_errors, lat_errors, proto_errors);
        if (data_errors + lat_errors + proto_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* mem_subsys_top.f */
+incdir+.
mem_pkg.sv
mem_arbiter.sv
data_memory.sv
mem_subsys_top.sv
tb_mem_subsys_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_subsys_top.f --top-module tb_mem_subsys_top \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_mem_subsys_top > sim.log 2>&1
cat sim.log

grep -qxF '** PASS **' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
